// ==== verilog/lif_pkg.sv ====
// LIF output stage definitions
package lif_pkg;

    // Default width of one partial sum and of the membrane potential.
    localparam int PSUM_W_DEF = 16;

    // Default number of time steps carried in one partial-sum word.
    localparam int TIME_STEPS_DEF = 4;

    // Default maximum number of pixels in one image row.
    localparam int IMG_WIDTH_DEF = 16;

    // Width of the configuration words.
    localparam int CFG_W = 16;

    // Threshold and row length are both carried as unsigned words.
    typedef logic [CFG_W-1:0] cfg_t;

    // Arithmetic right shift applied to the incoming membrane potential.
    // A shift of one halves the potential between time steps.
    localparam int LEAK_SHIFT = 1;

endpackage

// ==== verilog/psum_bias_add.sv ====
// Partial sum bias adder
`timescale 1ns/1ps

module psum_bias_add #(
    parameter int PSUM_W     = 16,
    parameter int TIME_STEPS = 4
) (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic                           i_psum_valid,
    input  logic [PSUM_W*TIME_STEPS-1:0]   i_psum_data,
    input  logic signed [PSUM_W-1:0]       i_bias,
    output logic                           o_bias_valid,
    output logic [PSUM_W*TIME_STEPS-1:0]   o_bias_data
);

    logic                         psum_valid_q;
    logic [PSUM_W*TIME_STEPS-1:0] psum_q;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            psum_valid_q <= 1'b0;
            o_bias_valid <= 1'b0;
        end else begin
            psum_valid_q <= i_psum_valid;
            o_bias_valid <= psum_valid_q;
        end
    end

    // The same bias is added to every time step of the pixel.
    // The sum wraps in PSUM_W bits.
    always_ff @(posedge s_clk) begin
        psum_q <= i_psum_data;
        for (int t = 0; t < TIME_STEPS; t++) begin
            o_bias_data[t*PSUM_W +: PSUM_W] <= $signed(psum_q[t*PSUM_W +: PSUM_W]) + i_bias;
        end
    end

endmodule

// ==== verilog/lif_neuron.sv ====
// Leaky integrate-and-fire step
`timescale 1ns/1ps

module lif_neuron import lif_pkg::*; #(
    parameter int PSUM_W = 16
) (
    input  logic                     s_clk,
    input  logic                     s_rst,
    input  cfg_t                     i_thrd,
    input  logic                     i_valid,
    input  logic signed [PSUM_W-1:0] i_delta,
    input  logic signed [PSUM_W-1:0] i_pre_mem,
    output logic                     o_valid,
    output logic                     o_spike,
    output logic signed [PSUM_W-1:0] o_nxt_mem
);

    // One extra bit keeps the threshold non-negative in the signed compare.
    localparam int CMP_W = ((PSUM_W > CFG_W) ? PSUM_W : CFG_W) + 1;

    logic signed [PSUM_W-1:0] mem;
    logic signed [CMP_W-1:0]  mem_ext;
    logic signed [CMP_W-1:0]  thrd_ext;
    logic                     fire;

    // Leak the carried potential, then integrate this step's input.
    assign mem      = (i_pre_mem >>> LEAK_SHIFT) + i_delta;
    assign mem_ext  = mem;
    assign thrd_ext = i_thrd;
    assign fire     = (mem_ext >= thrd_ext);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Hard reset of the potential after a spike.
    always_ff @(posedge s_clk) begin
        o_spike   <= fire;
        o_nxt_mem <= fire ? '0 : mem;
    end

endmodule

// ==== verilog/lif_time_chain.sv ====
// LIF time step chain
`timescale 1ns/1ps

module lif_time_chain import lif_pkg::*; #(
    parameter int PSUM_W     = 16,
    parameter int TIME_STEPS = 4
) (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         i_cfg_valid,
    input  cfg_t                         i_lif_thrd,
    input  logic                         i_valid,
    input  logic [PSUM_W*TIME_STEPS-1:0] i_data,
    output logic                         o_spike_valid,
    output logic [TIME_STEPS-1:0]        o_spike_vec
);

    cfg_t                     thrd_q;
    logic [TIME_STEPS-1:0]    nrn_in_valid;
    logic [TIME_STEPS-1:0]    nrn_valid;
    logic [TIME_STEPS-1:0]    nrn_spike;
    logic signed [PSUM_W-1:0] nrn_delta [TIME_STEPS];
    logic signed [PSUM_W-1:0] nrn_pre   [TIME_STEPS];
    logic signed [PSUM_W-1:0] nrn_mem   [TIME_STEPS];

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            thrd_q <= '0;
        end else if (i_cfg_valid) begin
            thrd_q <= i_lif_thrd;
        end
    end

    for (genvar t = 0; t < TIME_STEPS; t++) begin : g_step
        if (t == 0) begin : g_head
            assign nrn_delta[t]    = i_data[0 +: PSUM_W];
            assign nrn_pre[t]      = '0;
            assign nrn_in_valid[t] = i_valid;
        end else begin : g_link
            // Slice t waits t cycles so it meets the potential from step t-1.
            logic signed [PSUM_W-1:0] skew_q [t];

            always_ff @(posedge s_clk) begin
                skew_q[0] <= i_data[t*PSUM_W +: PSUM_W];
                for (int k = 1; k < t; k++) begin
                    skew_q[k] <= skew_q[k-1];
                end
            end

            assign nrn_delta[t]    = skew_q[t-1];
            assign nrn_pre[t]      = nrn_mem[t-1];
            assign nrn_in_valid[t] = nrn_valid[t-1];
        end

        lif_neuron #(
            .PSUM_W    (PSUM_W)
        ) u_neuron (
            .s_clk     (s_clk),
            .s_rst     (s_rst),
            .i_thrd    (thrd_q),
            .i_valid   (nrn_in_valid[t]),
            .i_delta   (nrn_delta[t]),
            .i_pre_mem (nrn_pre[t]),
            .o_valid   (nrn_valid[t]),
            .o_spike   (nrn_spike[t]),
            .o_nxt_mem (nrn_mem[t])
        );

        if (t == TIME_STEPS - 1) begin : g_last
            assign o_spike_vec[t] = nrn_spike[t];
        end else begin : g_deskew
            // Early spikes are held back until the last step has fired.
            localparam int DLY = TIME_STEPS - 1 - t;
            logic [DLY-1:0] dly_q;

            always_ff @(posedge s_clk) begin
                dly_q[0] <= nrn_spike[t];
                for (int k = 1; k < DLY; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end

            assign o_spike_vec[t] = dly_q[DLY-1];
        end
    end

    assign o_spike_valid = nrn_valid[TIME_STEPS-1];

endmodule

// ==== verilog/spike_line_packer.sv ====
// Spike line packer
`timescale 1ns/1ps

module spike_line_packer import lif_pkg::*; #(
    parameter int TIME_STEPS = 4,
    parameter int IMG_WIDTH  = 16
) (
    input  logic                            s_clk,
    input  logic                            s_rst,
    input  logic                            i_cfg_valid,
    input  cfg_t                            i_img_size,
    input  logic                            i_spike_valid,
    input  logic [TIME_STEPS-1:0]           i_spike_vec,
    output logic                            o_line_valid,
    output logic [IMG_WIDTH*TIME_STEPS-1:0] o_line_spikes
);

    localparam int CNT_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;

    cfg_t                            img_size_q;
    logic [CNT_W-1:0]                pix_cnt;
    logic [IMG_WIDTH*TIME_STEPS-1:0] line_acc;
    logic [IMG_WIDTH*TIME_STEPS-1:0] line_nxt;
    logic                            last_pix;

    // A row also ends at the full width, so an unset row length of zero
    // behaves as IMG_WIDTH pixels.
    assign last_pix = (pix_cnt == CNT_W'(IMG_WIDTH - 1)) ||
                      ((CFG_W'(pix_cnt) + CFG_W'(1)) == img_size_q);

    // Time-step-major layout. Step t of pixel p lands on bit t*IMG_WIDTH+p.
    always_comb begin
        line_nxt = line_acc;
        for (int t = 0; t < TIME_STEPS; t++) begin
            line_nxt[t*IMG_WIDTH + int'(pix_cnt)] = i_spike_vec[t];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            img_size_q   <= '0;
            pix_cnt      <= '0;
            line_acc     <= '0;
            o_line_valid <= 1'b0;
        end else begin
            o_line_valid <= 1'b0;
            if (i_cfg_valid) begin
                img_size_q <= i_img_size;
            end
            if (i_spike_valid) begin
                if (last_pix) begin
                    pix_cnt      <= '0;
                    line_acc     <= '0;
                    o_line_valid <= 1'b1;
                end else begin
                    pix_cnt  <= pix_cnt + 1'b1;
                    line_acc <= line_nxt;
                end
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_spike_valid && last_pix) begin
            o_line_spikes <= line_nxt;
        end
    end

endmodule

// ==== verilog/psum_lif_top.sv ====
// Convolution LIF output stage
`timescale 1ns/1ps

module psum_lif_top import lif_pkg::*; #(
    parameter int PSUM_W     = PSUM_W_DEF,
    parameter int TIME_STEPS = TIME_STEPS_DEF,
    parameter int IMG_WIDTH  = IMG_WIDTH_DEF
) (
    input  logic                            s_clk,
    input  logic                            s_rst,
    input  logic                            i_cfg_valid,
    input  cfg_t                            i_lif_thrd,
    input  cfg_t                            i_img_size,
    input  logic                            i_psum_valid,
    input  logic [PSUM_W*TIME_STEPS-1:0]    i_psum_data,
    input  logic signed [PSUM_W-1:0]        i_bias,
    output logic                            o_line_valid,
    output logic [IMG_WIDTH*TIME_STEPS-1:0] o_line_spikes
);

    logic                         bias_valid;
    logic [PSUM_W*TIME_STEPS-1:0] bias_data;
    logic                         spike_valid;
    logic [TIME_STEPS-1:0]        spike_vec;

    psum_bias_add #(
        .PSUM_W        (PSUM_W),
        .TIME_STEPS    (TIME_STEPS)
    ) u_bias (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_psum_valid  (i_psum_valid),
        .i_psum_data   (i_psum_data),
        .i_bias        (i_bias),
        .o_bias_valid  (bias_valid),
        .o_bias_data   (bias_data)
    );

    lif_time_chain #(
        .PSUM_W        (PSUM_W),
        .TIME_STEPS    (TIME_STEPS)
    ) u_chain (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_cfg_valid   (i_cfg_valid),
        .i_lif_thrd    (i_lif_thrd),
        .i_valid       (bias_valid),
        .i_data        (bias_data),
        .o_spike_valid (spike_valid),
        .o_spike_vec   (spike_vec)
    );

    spike_line_packer #(
        .TIME_STEPS    (TIME_STEPS),
        .IMG_WIDTH     (IMG_WIDTH)
    ) u_packer (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_cfg_valid   (i_cfg_valid),
        .i_img_size    (i_img_size),
        .i_spike_valid (spike_valid),
        .i_spike_vec   (spike_vec),
        .o_line_valid  (o_line_valid),
        .o_line_spikes (o_line_spikes)
    );

endmodule

// ==== verification/psum_lif_assertions.sv ====
// Output stage port assertions
`timescale 1ns/1ps

module psum_lif_assertions import lif_pkg::*; #(
    parameter int TIME_STEPS = 4,
    parameter int IMG_WIDTH  = 16
) (
    input logic s_clk,
    input logic s_rst,
    input logic i_cfg_valid,
    input cfg_t i_img_size,
    input logic i_psum_valid,
    input logic o_line_valid
);

    // Input register, bias stage, one cycle per neuron and the packer.
    localparam int LINE_LAT = TIME_STEPS + 3;

    line_low_in_reset: assert property (@(posedge s_clk) s_rst |-> !o_line_valid)
        else $error("o_line_valid is high during reset");

    // A line can only close on a pixel that entered LINE_LAT cycles before.
    line_after_pixel: assert property (@(posedge s_clk) disable iff (s_rst)
        o_line_valid |-> $past(i_psum_valid, LINE_LAT))
        else $error("o_line_valid without a pixel %0d cycles earlier", LINE_LAT);

    img_size_legal: assert property (@(posedge s_clk) disable iff (s_rst)
        i_cfg_valid |-> (i_img_size >= cfg_t'(1) && i_img_size <= cfg_t'(IMG_WIDTH)))
        else $error("i_img_size %0d is outside 1 to %0d", i_img_size, IMG_WIDTH);

endmodule

bind psum_lif_top psum_lif_assertions #(
    .TIME_STEPS   (TIME_STEPS),
    .IMG_WIDTH    (IMG_WIDTH)
) u_assertions (
    .s_clk        (s_clk),
    .s_rst        (s_rst),
    .i_cfg_valid  (i_cfg_valid),
    .i_img_size   (i_img_size),
    .i_psum_valid (i_psum_valid),
    .o_line_valid (o_line_valid)
);

// ==== verification/psum_lif_tb.sv ====
// LIF output stage testbench
`timescale 1ns/1ps

module psum_lif_tb import lif_pkg::*; ();

    localparam int PSUM_W       = PSUM_W_DEF;
    localparam int TIME_STEPS   = TIME_STEPS_DEF;
    localparam int IMG_WIDTH    = IMG_WIDTH_DEF;
    localparam int LINE_W       = IMG_WIDTH * TIME_STEPS;
    localparam int WORD_W       = PSUM_W * TIME_STEPS;
    localparam int LINE_TIMEOUT = 200;
    localparam int DRAIN_CYCLES = TIME_STEPS + 6;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [WORD_W-1:0] word_t;

    logic                     s_clk;
    logic                     s_rst;
    logic                     i_cfg_valid;
    cfg_t                     i_lif_thrd;
    cfg_t                     i_img_size;
    logic                     i_psum_valid;
    word_t                    i_psum_data;
    logic signed [PSUM_W-1:0] i_bias;
    logic                     o_line_valid;
    line_t                    o_line_spikes;

    word_t       row_buf [2*IMG_WIDTH];
    line_t       exp_q [$];
    line_t       rx_q [$];
    logic [31:0] lfsr_state;
    int          cur_thrd;
    int          cur_size;
    int          cur_bias;
    int          err_cnt;
    int          test_cnt;
    int          fail_cnt;

    psum_lif_top #(
        .PSUM_W        (PSUM_W),
        .TIME_STEPS    (TIME_STEPS),
        .IMG_WIDTH     (IMG_WIDTH)
    ) u_dut (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_cfg_valid   (i_cfg_valid),
        .i_lif_thrd    (i_lif_thrd),
        .i_img_size    (i_img_size),
        .i_psum_valid  (i_psum_valid),
        .i_psum_data   (i_psum_data),
        .i_bias        (i_bias),
        .o_line_valid  (o_line_valid),
        .o_line_spikes (o_line_spikes)
    );

    initial begin
        s_clk = 1'b0;
        forever #4 s_clk = ~s_clk;
    end

    // Lines are collected at the falling edge, where the outputs are stable.
    always @(negedge s_clk) begin
        if (!s_rst && o_line_valid) begin
            rx_q.push_back(o_line_spikes);
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic int take_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi, input int bits);
        return lo + (take_bits(bits) % (hi - lo + 1));
    endfunction

    // The neuron rule is carried in int so that nothing wraps.
    function automatic logic [TIME_STEPS-1:0] model_pixel(input word_t w, input int bias,
                                                          input int thrd);
        logic [TIME_STEPS-1:0] vec;
        int                    pre;
        int                    mem;
        vec = '0;
        pre = 0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            mem = (pre >>> LEAK_SHIFT) + int'($signed(w[t*PSUM_W +: PSUM_W])) + bias;
            vec[t] = (mem >= thrd);
            pre = vec[t] ? 0 : mem;
        end
        return vec;
    endfunction

    function automatic line_t model_line(input int base, input int size);
        line_t                 line;
        logic [TIME_STEPS-1:0] vec;
        int                    n;
        line = '0;
        n = (size < 1 || size > IMG_WIDTH) ? IMG_WIDTH : size;
        for (int p = 0; p < n; p++) begin
            vec = model_pixel(row_buf[base + p], cur_bias, cur_thrd);
            for (int t = 0; t < TIME_STEPS; t++) begin
                line[t*IMG_WIDTH + p] = vec[t];
            end
        end
        return line;
    endfunction

    task automatic fill_ramp(input int start, input int dp, input int dt);
        word_t w;
        for (int p = 0; p < IMG_WIDTH; p++) begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                w[t*PSUM_W +: PSUM_W] = PSUM_W'(start + p*dp + t*dt);
            end
            row_buf[p] = w;
        end
    endtask

    task automatic fill_random(input int base, input int n);
        word_t w;
        for (int p = 0; p < n; p++) begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                w[t*PSUM_W +: PSUM_W] = PSUM_W'(rand_range(-2000, 2000, 12));
            end
            row_buf[base + p] = w;
        end
    endtask

    task automatic configure(input int thrd, input int size);
        @(negedge s_clk);
        i_cfg_valid = 1'b1;
        i_lif_thrd  = cfg_t'(thrd);
        i_img_size  = cfg_t'(size);
        @(negedge s_clk);
        i_cfg_valid = 1'b0;
        cur_thrd    = thrd;
        cur_size    = size;
    endtask

    task automatic set_bias(input int bias);
        @(negedge s_clk);
        i_bias   = PSUM_W'(bias);
        cur_bias = bias;
    endtask

    task automatic send_pixels(input int n);
        for (int p = 0; p < n; p++) begin
            @(negedge s_clk);
            i_psum_valid = 1'b1;
            i_psum_data  = row_buf[p];
        end
        @(negedge s_clk);
        i_psum_valid = 1'b0;
    endtask

    task automatic wait_lines(input int n);
        int cyc;
        cyc = 0;
        while (rx_q.size() < n && cyc < LINE_TIMEOUT) begin
            @(negedge s_clk);
            cyc++;
        end
        if (rx_q.size() < n) begin
            $display("Timeout at %0d ns: only %0d of %0d lines arrived",
                     $time, rx_q.size(), n);
            err_cnt++;
        end
    endtask

    task automatic compare_line(input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("Error at %0d ns: o_line_spikes expected %h, got %h", $time, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_count(input int exp, input int act);
        if (act != exp) begin
            $display("Error at %0d ns: o_line_valid count expected %0d, got %0d",
                     $time, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_lines(inout int seen);
        while (rx_q.size() > 0) begin
            if (exp_q.size() == 0) begin
                $display("A line arrived at %0d ns when none was expected", $time);
                err_cnt++;
                void'(rx_q.pop_front());
            end else begin
                compare_line(exp_q.pop_front(), rx_q.pop_front());
            end
            seen++;
        end
    endtask

    // Idle long enough for any stray line to leave the pipeline, then count.
    task automatic drain_and_count(input int exp_lines, inout int seen);
        repeat (DRAIN_CYCLES) @(negedge s_clk);
        check_lines(seen);
        compare_count(exp_lines, seen);
    endtask

    task automatic end_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, err_cnt - err_before);
        end
        exp_q.delete();
        rx_q.delete();
    endtask

    task automatic test_reset_threshold();
        int errs0;
        int seen;
        errs0 = err_cnt;
        seen  = 0;
        // Reset leaves a zero threshold, and a zero row length acts as the full width.
        set_bias(0);
        fill_ramp(100, 5, 1);
        exp_q.push_back({LINE_W{1'b1}});
        send_pixels(IMG_WIDTH);
        wait_lines(1);
        check_lines(seen);
        configure(30000, IMG_WIDTH);
        exp_q.push_back(line_t'(0));
        send_pixels(IMG_WIDTH);
        wait_lines(1);
        drain_and_count(2, seen);
        end_test("reset_threshold", errs0);
    endtask

    task automatic test_leak();
        int errs0;
        int seen;
        errs0 = err_cnt;
        seen  = 0;
        // Sums 60, 70, 80, 90 fire at steps 1 and 3 with a threshold of 100.
        configure(100, IMG_WIDTH);
        set_bias(0);
        fill_ramp(60, 0, 10);
        exp_q.push_back(model_line(0, cur_size));
        send_pixels(IMG_WIDTH);
        wait_lines(1);
        drain_and_count(1, seen);
        end_test("leak_integration", errs0);
    endtask

    task automatic test_bias();
        int errs0;
        int seen;
        int biases [3];
        errs0  = err_cnt;
        seen   = 0;
        biases = '{0, -300, 300};
        configure(250, IMG_WIDTH);
        fill_ramp(100, 13, 7);
        for (int i = 0; i < 3; i++) begin
            set_bias(biases[i]);
            exp_q.push_back(model_line(0, cur_size));
            send_pixels(IMG_WIDTH);
            wait_lines(1);
            check_lines(seen);
        end
        drain_and_count(3, seen);
        end_test("signed_bias", errs0);
    endtask

    task automatic test_short_rows();
        int errs0;
        int seen;
        errs0 = err_cnt;
        seen  = 0;
        configure(150, 5);
        set_bias(rand_range(-500, 500, 10));
        fill_random(0, 10);
        exp_q.push_back(model_line(0, 5));
        exp_q.push_back(model_line(5, 5));
        send_pixels(10);
        wait_lines(2);
        drain_and_count(2, seen);
        end_test("short_rows", errs0);
    endtask

    task automatic test_random_stream();
        int errs0;
        int seen;
        errs0 = err_cnt;
        seen  = 0;
        for (int r = 0; r < 8; r++) begin
            configure(rand_range(0, 3000, 12), IMG_WIDTH);
            set_bias(rand_range(-500, 500, 10));
            fill_random(0, IMG_WIDTH);
            exp_q.push_back(model_line(0, cur_size));
            send_pixels(IMG_WIDTH);
            wait_lines(1);
            check_lines(seen);
        end
        drain_and_count(8, seen);
        end_test("random_stream", errs0);
    endtask

    initial begin
        s_rst        = 1'b1;
        i_cfg_valid  = 1'b0;
        i_lif_thrd   = '0;
        i_img_size   = '0;
        i_psum_valid = 1'b0;
        i_psum_data  = '0;
        i_bias       = '0;
        lfsr_state   = 32'd90411;
        cur_thrd     = 0;
        cur_size     = 0;
        cur_bias     = 0;
        err_cnt      = 0;
        test_cnt     = 0;
        fail_cnt     = 0;
        repeat (10) @(posedge s_clk);
        @(negedge s_clk);
        s_rst = 1'b0;

        test_reset_threshold();
        test_leak();
        test_bias();
        test_short_rows();
        test_random_stream();

        $display("Tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/lif_pkg.sv
verilog/psum_bias_add.sv
verilog/lif_neuron.sv
verilog/lif_time_chain.sv
verilog/spike_line_packer.sv
verilog/psum_lif_top.sv
verification/psum_lif_assertions.sv
verification/psum_lif_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=psum_lif_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f \
    --top-module psum_lif_tb \
    -Mdir "${BUILD_DIR}" \
    -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
    echo "Simulation exited with status ${sim_status}"
    exit 1
fi

if grep -qx "Testbench passed" "${LOG_FILE}"; then
    echo "Simulation result: PASS"
    exit 0
fi

echo "Simulation result: FAIL"
exit 1
